/* include/halfband_cfg.svh */
// Halfband decimator sizes, fraction bits, FIFO depth and credit counts.
`ifndef HALFBAND_CFG_SVH
`define HALFBAND_CFG_SVH

// ################################################
// Sample and accumulator widths
// ################################################

`define HB_SAMPLE_W 12        // Q2.10 input and output samples.
`define HB_COEF_FRAC 11       // Coefficients are in units of 1/2048.
`define HB_ACC_W 26           // Branch sums scaled by 2048 with sign margin.

// ################################################
// Output buffering and flow control
// ################################################

`define HB_OUT_FIFO_DEPTH 4   // Show-ahead output FIFO entries.

// Upstream sample credits after reset, twice the FIFO depth.
`define HB_IN_CREDITS 8

`define HB_OUT_CREDITS 3      // Downstream buffer credits after reset.
`define HB_CREDIT_W 4         // Credit counter width.

`endif

/* verilog/halfband_pkg.sv */
// Halfband decimator shared types for samples, branch sums and pairer phase.
package halfband_pkg;

`include "halfband_cfg.svh"

    // ################################################
    // Data types
    // ################################################

    // Input samples, paired samples and output words.
    typedef logic signed [`HB_SAMPLE_W-1:0] sample_t;

    // Branch results, still scaled by 2048.
    typedef logic signed [`HB_ACC_W-1:0] branch_sum_t;

    // ################################################
    // Control types
    // ################################################

    // Which sample the pairer expects next.
    typedef enum logic {
        PHASE_ODD,   // Waiting for x[2m-1].
        PHASE_EVEN   // Odd sample held, waiting for x[2m].
    } pair_phase_e;

endpackage

/* verilog/halfband_input_pairer.sv */
// Input pairer joining each odd sample with the next even sample for both branches.
module halfband_input_pairer (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  in_valid,
    input  halfband_pkg::sample_t in_data,
    output logic                  pair_valid,
    output halfband_pkg::sample_t pair_odd,
    output halfband_pkg::sample_t pair_even
);

    halfband_pkg::pair_phase_e phase;
    halfband_pkg::sample_t     odd_hold;   // Waiting odd sample.

    // ################################################
    // Phase tracking and pair strobe
    // ################################################

    always_ff @(posedge clk) begin
        if (!rstn) begin
            phase      <= halfband_pkg::PHASE_ODD;
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= 1'b0;
            if (in_valid) begin
                if (phase == halfband_pkg::PHASE_ODD) begin
                    phase <= halfband_pkg::PHASE_EVEN;
                end else begin
                    phase      <= halfband_pkg::PHASE_ODD;
                    pair_valid <= 1'b1;   // One strobe per completed pair.
                end
            end
        end
    end

    // ################################################
    // Sample registers
    // ################################################

    always_ff @(posedge clk) begin
        if (in_valid) begin
            if (phase == halfband_pkg::PHASE_ODD) begin
                odd_hold <= in_data;
            end else begin
                // Both samples leave together on the common decimated time base.
                pair_odd  <= odd_hold;
                pair_even <= in_data;
            end
        end
    end

endmodule

/* verilog/halfband_even_phase.sv */
// Even polyphase branch with symmetric pre-adds and shared-term shift-add taps.
module halfband_even_phase (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      pair_valid,
    input  halfband_pkg::sample_t     pair_even,
    output logic                      even_valid,
    output halfband_pkg::branch_sum_t even_sum
);

    // Delay line e[m-1]..e[m-4], pair_even is e[m].
    halfband_pkg::sample_t e_d1;
    halfband_pkg::sample_t e_d2;
    halfband_pkg::sample_t e_d3;
    halfband_pkg::sample_t e_d4;

    halfband_pkg::branch_sum_t pre_outer;     // e[m] + e[m-4].
    halfband_pkg::branch_sum_t pre_inner;     // e[m-1] + e[m-3].
    halfband_pkg::branch_sum_t centre;        // e[m-2].
    halfband_pkg::branch_sum_t three_outer;
    halfband_pkg::branch_sum_t three_inner;
    halfband_pkg::branch_sum_t prod_outer;
    halfband_pkg::branch_sum_t prod_inner;
    halfband_pkg::branch_sum_t prod_centre;
    halfband_pkg::branch_sum_t tap_sum;

    // ################################################
    // Symmetric pre-addition
    // ################################################

    assign pre_outer = halfband_pkg::branch_sum_t'(pair_even)
                     + halfband_pkg::branch_sum_t'(e_d4);
    assign pre_inner = halfband_pkg::branch_sum_t'(e_d1)
                     + halfband_pkg::branch_sum_t'(e_d3);
    assign centre    = halfband_pkg::branch_sum_t'(e_d2);

    // Three-times terms, each formed once per pair.
    assign three_outer = (pre_outer <<< 1) + pre_outer;
    assign three_inner = (pre_inner <<< 1) + pre_inner;

    // ################################################
    // Canonic signed digit products
    // ################################################

    // h0 = h8 = -26 = -(32 - 2*3).
    assign prod_outer = (three_outer <<< 1) - (pre_outer <<< 5);

    // h2 = h6 = 150 = 128 + 16 + 2*3.
    assign prod_inner = (pre_inner <<< 7) + (pre_inner <<< 4) + (three_inner <<< 1);

    // h4 = 776 = 512 + 256 + 8.
    assign prod_centre = (centre <<< 9) + (centre <<< 8) + (centre <<< 3);

    assign tap_sum = prod_outer + prod_inner + prod_centre;

    // ################################################
    // Delay line and output register
    // ################################################

    always_ff @(posedge clk) begin
        if (!rstn) begin
            even_valid <= 1'b0;
            e_d1       <= '0;
            e_d2       <= '0;
            e_d3       <= '0;
            e_d4       <= '0;
        end else begin
            even_valid <= pair_valid;
            if (pair_valid) begin   // Advances once per decimated sample.
                e_d1 <= pair_even;
                e_d2 <= e_d1;
                e_d3 <= e_d2;
                e_d4 <= e_d3;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pair_valid) begin
            even_sum <= tap_sum;
        end
    end

endmodule

/* verilog/halfband_odd_phase.sv */
// Odd polyphase branch summing the two power-of-two centre-adjacent taps.
module halfband_odd_phase (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      pair_valid,
    input  halfband_pkg::sample_t     pair_odd,
    output halfband_pkg::branch_sum_t odd_sum
);

    // Delay line o[m-1] and o[m-2], pair_odd is o[m].
    halfband_pkg::sample_t o_d1;
    halfband_pkg::sample_t o_d2;

    halfband_pkg::branch_sum_t tap_pair;
    halfband_pkg::branch_sum_t tap_sum;

    // ################################################
    // Tap sum
    // ################################################

    // h3 and h5 land on x[2m-3] and x[2m-5].
    assign tap_pair = halfband_pkg::branch_sum_t'(o_d1)
                    + halfband_pkg::branch_sum_t'(o_d2);

    assign tap_sum = tap_pair <<< 9;   // Both taps are 512.

    // ################################################
    // Delay line and output register
    // ################################################

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_d1 <= '0;
            o_d2 <= '0;
        end else if (pair_valid) begin
            o_d1 <= pair_odd;
            o_d2 <= o_d1;
        end
    end

    // Same one-cycle latency as the even branch.
    always_ff @(posedge clk) begin
        if (pair_valid) begin
            odd_sum <= tap_sum;
        end
    end

endmodule

/* verilog/halfband_combiner.sv */
// Halfband combiner that rounds and saturates the branch sum and runs both credit loops.
`include "halfband_cfg.svh"

module halfband_combiner (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      even_valid,
    input  halfband_pkg::branch_sum_t even_sum,
    input  halfband_pkg::branch_sum_t odd_sum,
    input  logic                      out_credit,
    output logic                      out_valid,
    output halfband_pkg::sample_t     out_data,
    output logic                      in_credit
);

    halfband_pkg::branch_sum_t total;
    halfband_pkg::branch_sum_t rounded;
    halfband_pkg::sample_t     sat_word;

    halfband_pkg::sample_t fifo_mem [`HB_OUT_FIFO_DEPTH];

    logic [$clog2(`HB_OUT_FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(`HB_OUT_FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(`HB_OUT_FIFO_DEPTH+1)-1:0] fifo_count;
    logic [`HB_CREDIT_W-1:0]                 out_cred;

    logic push;
    logic pop;

    // ################################################
    // Branch sum, rounding and saturation
    // ################################################

    // Half-up rounding from the coefficient fraction bits.
    assign total   = even_sum + odd_sum + (1 <<< (`HB_COEF_FRAC - 1));
    assign rounded = total >>> `HB_COEF_FRAC;

    always_comb begin
        if (rounded > (2 ** (`HB_SAMPLE_W - 1)) - 1) begin
            sat_word = {1'b0, {(`HB_SAMPLE_W - 1){1'b1}}};   // Clip to +max.
        end else if (rounded < -(2 ** (`HB_SAMPLE_W - 1))) begin
            sat_word = {1'b1, {(`HB_SAMPLE_W - 1){1'b0}}};   // Clip to -max.
        end else begin
            sat_word = rounded[`HB_SAMPLE_W-1:0];
        end
    end

    // ################################################
    // Output FIFO
    // ################################################

    assign push = even_valid;
    assign pop  = out_valid;

    // Show-ahead read port.
    assign out_data = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= sat_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == `HB_OUT_FIFO_DEPTH - 1) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == `HB_OUT_FIFO_DEPTH - 1) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({push, pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    // ################################################
    // Credit loops
    // ################################################

    // A word leaves only with a downstream credit in hand.
    assign out_valid = (fifo_count != '0) && (out_cred != '0);

    // Each popped word frees room for two more input samples.
    assign in_credit = pop;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_cred <= `HB_CREDIT_W'(`HB_OUT_CREDITS);
        end else begin
            case ({pop, out_credit})
                2'b10:   out_cred <= out_cred - 1'b1;   // Spend.
                2'b01:   out_cred <= out_cred + 1'b1;   // Return.
                default: out_cred <= out_cred;          // Both or neither.
            endcase
        end
    end

endmodule

/* verilog/halfband_decimator.sv */
// Half-band decimate-by-two FIR top level with credit-based flow control.
module halfband_decimator (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  in_valid,
    input  halfband_pkg::sample_t in_data,
    output logic                  in_credit,
    output logic                  out_valid,
    output halfband_pkg::sample_t out_data,
    input  logic                  out_credit
);

    logic                      pair_valid;
    halfband_pkg::sample_t     pair_odd;
    halfband_pkg::sample_t     pair_even;
    logic                      even_valid;
    halfband_pkg::branch_sum_t even_sum;
    halfband_pkg::branch_sum_t odd_sum;

    halfband_input_pairer i_pairer (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .pair_valid (pair_valid),
        .pair_odd   (pair_odd),
        .pair_even  (pair_even)
    );

    // Both branches share the pair strobe.
    halfband_even_phase i_even (
        .clk        (clk),
        .rstn       (rstn),
        .pair_valid (pair_valid),
        .pair_even  (pair_even),
        .even_valid (even_valid),
        .even_sum   (even_sum)
    );

    halfband_odd_phase i_odd (
        .clk        (clk),
        .rstn       (rstn),
        .pair_valid (pair_valid),
        .pair_odd   (pair_odd),
        .odd_sum    (odd_sum)
    );

    halfband_combiner i_combiner (
        .clk        (clk),
        .rstn       (rstn),
        .even_valid (even_valid),
        .even_sum   (even_sum),
        .odd_sum    (odd_sum),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .in_credit  (in_credit)
    );

endmodule

/* tb/halfband_tb.sv */
// Halfband decimator testbench with credit source, credit sink, reference model and assertions.
`include "halfband_cfg.svh"

module halfband_tb;

    localparam integer N_SAMPLES = 460;
    localparam integer N_OUT     = N_SAMPLES / 2;
    localparam integer OVF_BASE  = 400;   // Saturating pattern.
    localparam integer INV_BASE  = 410;   // Same pattern inverted.
    localparam integer DC_BASE   = 420;
    localparam integer STALL_LEN = 300;
    localparam integer TIMEOUT_CYCLES = 6 * N_SAMPLES + 2 * STALL_LEN + 500;

    logic                  clk;
    logic                  rstn;
    logic                  in_valid;
    halfband_pkg::sample_t in_data;
    logic                  in_credit;
    logic                  out_valid;
    halfband_pkg::sample_t out_data;
    logic                  out_credit;

    halfband_pkg::sample_t stim [N_SAMPLES];   // Every sample in send order.

    logic [31:0] lcg_state;
    logic [31:0] rnd;
    integer      n_sent;
    integer      n_acc;
    integer      n_pairs;
    integer      n_valid;
    integer      n_returned;
    integer      owed;          // Words taken by the sink whose credit is still owed.
    integer      ret_delay;
    integer      stall_left;
    integer      stalls_done;
    integer      src_credits;
    integer      lat_cnt;
    integer      cycle_count;
    integer      reset_cycles;
    integer      dut_cred;

    halfband_decimator i_dut (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ################################################
    // Helpers and reference model
    // ################################################

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at the first error.");
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic integer tap_coef(input integer k);
        case (k)
            0, 8:    return -26;
            2, 6:    return 150;
            3, 5:    return 512;
            4:       return 776;
            default: return 0;   // h1 and h7.
        endcase
    endfunction

    // y[m] from x[2m-k], with x[n] held in stim[n+1].
    function automatic integer ref_output(input integer m);
        integer acc;
        integer k;
        integer idx;
        integer y;
        acc = 0;
        for (k = 0; k < 9; k = k + 1) begin
            idx = 2 * m + 1 - k;
            if (idx >= 0) begin
                acc = acc + tap_coef(k) * stim[idx];
            end
        end
        y = (acc + (1 << (`HB_COEF_FRAC - 1))) >>> `HB_COEF_FRAC;
        if (y > 2047) y = 2047;
        if (y < -2048) y = -2048;
        return y;
    endfunction

    task automatic check_word();
        integer expected;
        if (n_valid >= N_OUT) begin
            $display("An output word arrived after all %0d expected words.", N_OUT);
            abort_run();
        end else begin
            expected = ref_output(n_valid);
            assert (out_data == halfband_pkg::sample_t'(expected)) else begin
                $display("[FAIL] out_data word %0d: got %h, expected %h",
                         n_valid, out_data, expected[11:0]);
                abort_run();
            end
            if (n_valid == (OVF_BASE + 8) / 2) begin
                assert (out_data == 12'h7ff) else begin
                    $display("[FAIL] out_data overflow: got %h, expected 7ff", out_data);
                    abort_run();
                end
            end
            if (n_valid == (INV_BASE + 8) / 2) begin
                assert (out_data == 12'h800) else begin
                    $display("[FAIL] out_data underflow: got %h, expected 800", out_data);
                    abort_run();
                end
            end
            if (n_valid >= (DC_BASE + 8) / 2) begin   // Window fully inside the step.
                assert (out_data == 12'h3e8) else begin
                    $display("[FAIL] out_data DC step: got %h, expected 3e8", out_data);
                    abort_run();
                end
            end
        end
    endtask

    // ################################################
    // Concurrent checks
    // ################################################

    assert property (@(posedge clk) disable iff (!rstn) in_credit == out_valid)
    else begin
        $display("[FAIL] in_credit=%h out_valid=%h", $sampled(in_credit), $sampled(out_valid));
        abort_run();
    end

    assert property (@(posedge clk) disable iff (!rstn) out_valid |-> !$isunknown(out_data))
    else begin
        $display("[FAIL] out_data=%h is unknown while out_valid is high", $sampled(out_data));
        abort_run();
    end

    // ################################################
    // Source, sink and per-cycle checks
    // ################################################

    always @(posedge clk) begin
        if (!rstn) begin
            reset_cycles = reset_cycles + 1;
            if (reset_cycles > 1) begin
                assert (out_valid === 1'b0 && in_credit === 1'b0) else begin
                    $display("[FAIL] in reset out_valid=%h in_credit=%h", out_valid, in_credit);
                    abort_run();
                end
            end
            in_valid   <= 1'b0;
            out_credit <= 1'b0;
        end else begin
            cycle_count = cycle_count + 1;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("Timeout after %0d cycles with %0d words received.",
                         cycle_count, n_valid);
                abort_run();
            end
            if (lat_cnt > 0) begin   // Counting down to the expected first out_valid.
                lat_cnt = lat_cnt - 1;
                assert (out_valid === (lat_cnt == 0)) else begin
                    $display("[FAIL] out_valid=%h, expected %h, %0d cycles after even sample",
                             out_valid, lat_cnt == 0, 3 - lat_cnt);
                    abort_run();
                end
            end
            if (n_pairs == 0) begin
                assert (out_valid === 1'b0 && in_credit === 1'b0) else begin
                    $display("[FAIL] before first pair out_valid=%h in_credit=%h",
                             out_valid, in_credit);
                    abort_run();
                end
            end
            dut_cred = `HB_OUT_CREDITS + n_returned - n_valid;
            if (stall_left > 0 && dut_cred == 0) begin
                assert (out_valid === 1'b0) else begin
                    $display("[FAIL] out_valid=%h during a stall with no credits", out_valid);
                    abort_run();
                end
            end
            if (out_valid === 1'b1) begin
                check_word();
                n_valid = n_valid + 1;
                owed    = owed + 1;
            end
            assert (n_valid <= `HB_OUT_CREDITS + n_returned) else begin
                $display("The block sent %0d words with only %0d credits granted.",
                         n_valid, `HB_OUT_CREDITS + n_returned);
                abort_run();
            end
            if (out_credit) n_returned = n_returned + 1;

            // Input side accounting.
            if (in_credit === 1'b1) src_credits = src_credits + 2;
            assert (src_credits <= `HB_IN_CREDITS) else begin
                $display("The block returned more sample credits than the source spent.");
                abort_run();
            end
            if (in_valid) begin
                n_acc = n_acc + 1;
                if (n_acc % 2 == 0) begin   // Even sample accepted at this edge.
                    dut_cred = `HB_OUT_CREDITS + n_returned - n_valid;
                    if (n_pairs == n_valid && dut_cred > 0) lat_cnt = 3;
                    n_pairs = n_pairs + 1;
                end
            end
            rnd = lcg_next();
            if (n_sent < N_SAMPLES && src_credits > 0 && rnd[31:30] != 2'b00) begin
                in_valid    <= 1'b1;
                in_data     <= stim[n_sent];
                n_sent      = n_sent + 1;
                src_credits = src_credits - 1;
            end else begin
                in_valid <= 1'b0;
            end

            // Sink with random return delays and two long stalls.
            if ((stalls_done == 0 && n_valid >= 40) || (stalls_done == 1 && n_valid >= 160)) begin
                stall_left  = STALL_LEN;
                stalls_done = stalls_done + 1;
            end
            if (stall_left > 0) begin
                stall_left = stall_left - 1;
                out_credit <= 1'b0;
            end else if (ret_delay > 0) begin
                ret_delay = ret_delay - 1;
                out_credit <= 1'b0;
            end else if (owed > 0) begin
                out_credit <= 1'b1;
                owed      = owed - 1;
                rnd       = lcg_next();
                ret_delay = rnd[30:29];
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    // ################################################
    // Stimulus build, reset and end of run
    // ################################################

    initial begin
        integer i;
        lcg_state = 32'd90686;
        for (i = 0; i < OVF_BASE; i = i + 1) begin
            rnd     = lcg_next();
            stim[i] = rnd[31:20];
        end
        for (i = 0; i < 10; i = i + 1) begin   // Offsets 1 and 9 meet h8 and h0.
            stim[OVF_BASE + i] = (i == 1 || i == 9) ? 12'h800 : 12'h7ff;
            stim[INV_BASE + i] = (i == 1 || i == 9) ? 12'h7ff : 12'h800;
        end
        for (i = DC_BASE; i < N_SAMPLES; i = i + 1) begin
            stim[i] = 12'sd1000;
        end
        rstn         = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        out_credit   = 1'b0;
        n_sent       = 0;
        n_acc        = 0;
        n_pairs      = 0;
        n_valid      = 0;
        n_returned   = 0;
        owed         = 0;
        ret_delay    = 0;
        stall_left   = 0;
        stalls_done  = 0;
        src_credits  = `HB_IN_CREDITS;
        lat_cnt      = 0;
        cycle_count  = 0;
        reset_cycles = 0;
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        wait (n_valid == N_OUT);
        repeat (50) @(posedge clk);   // Catch any stray extra word.
        if (n_valid == N_OUT && n_sent == N_SAMPLES) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("Received %0d words for %0d samples sent.", n_valid, n_sent);
            abort_run();
        end
    end

endmodule

/* halfband_dec.f */
+incdir+include
verilog/halfband_pkg.sv
verilog/halfband_input_pairer.sv
verilog/halfband_even_phase.sv
verilog/halfband_odd_phase.sv
verilog/halfband_combiner.sv
verilog/halfband_decimator.sv
tb/halfband_tb.sv

/* Bender.yml */
package:
  name: halfband_dec

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/halfband_pkg.sv
      - verilog/halfband_input_pairer.sv
      - verilog/halfband_even_phase.sv
      - verilog/halfband_odd_phase.sv
      - verilog/halfband_combiner.sv
      - verilog/halfband_decimator.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/halfband_tb.sv
